//--- verilog.f
+incdir+sim
common/fxpPkg.sv
common/filterPkg.sv
hw/cplxMulReg.sv
recursion/sampleProjector.sv
recursion/recursionStage.sv
recursion/recursionChannel.sv
hw/partialSum.sv
hw/lookbackRecursion.sv
sim/tbLookback.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tbLookback
FILELIST := verilog.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST)) sim/refModel.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Included inside tbLookback, after numChan is declared

localparam int pipeDepth = 6;

// Model state runs one edge ahead of the DUT state register
cplx_t refState [numChan];
fxp_t  delayLine [pipeDepth];
fxp_t  expectedResult = '0;

// Sum over the frame words, each sign extended and used as a plain integer
function automatic cplx_t projectFrame(chanCoef_t coef, logic [frameBits-1:0] frame);
    longint accRe;
    longint accIm;
    longint word;
    cplx_t  p;
    accRe = 0;
    accIm = 0;
    for (int j = 0; j < frameLen; j++) begin
        word = longint'($signed(frame[sampleBits*j +: sampleBits]));
        accRe = accRe + longint'(coef.feed[j].re) * word;
        accIm = accIm + longint'(coef.feed[j].im) * word;
    end
    // Wrap once at the end, same as wrapping after every add
    p.re = fxp_t'(accRe);
    p.im = fxp_t'(accIm);
    return p;
endfunction

// One rising edge of the model, fed with the inputs the DUT samples there
task automatic stepModel(logic rstLevel, logic [frameBits-1:0] frame, logic valid);
    cplx_t proj;
    cplx_t weighted;
    fxp_t  sum;
    if (!rstLevel) begin
        for (int c = 0; c < numChan; c++) begin
            refState[c] = '0;
        end
        for (int k = 0; k < pipeDepth; k++) begin
            delayLine[k] = '0;
        end
        expectedResult = '0;
    end else begin
        sum = '0;
        for (int c = 0; c < numChan; c++) begin
            proj = valid ? projectFrame(coefTable[c], frame) : cplx_t'('0);
            refState[c] = cplxAdd(proj, cplxMul(coefTable[c].pole, refState[c]));
            weighted = cplxMul(refState[c], coefTable[c].weight);
            sum = sum + weighted.re;
        end
        for (int k = pipeDepth - 1; k > 0; k--) begin
            delayLine[k] = delayLine[k-1];
        end
        delayLine[0] = sum;
        expectedResult = delayLine[pipeDepth-1];
    end
endtask

`endif

//--- sim/tbLookback.sv
`timescale 1ns/1ns

module tbLookback
    import fxpPkg::*;
    import filterPkg::*;
();

    localparam int numChan = 4;
    localparam int resetCycles = 8;
    localparam int idleCycles = 10;
    localparam int impulseTail = 40;
    localparam int streamCycles = 200;
    localparam int gapCycles = 200;
    localparam int extremeCycles = 20;
    localparam int preResetCycles = 30;
    localparam int midResetCycles = 3;
    localparam int postResetCycles = 40;
    localparam int drainCycles = 10;
    localparam int totalCycles = resetCycles + idleCycles + 1 + impulseTail
        + streamCycles + gapCycles + 3 * extremeCycles
        + preResetCycles + midResetCycles + postResetCycles + drainCycles;
    localparam int timeoutCycles = totalCycles + 50;

    localparam logic [sampleBits-1:0] maxWord = {1'b0, {(sampleBits-1){1'b1}}};
    localparam logic [sampleBits-1:0] minWord = {1'b1, {(sampleBits-1){1'b0}}};
    localparam logic [frameBits-1:0] maxFrame = {frameLen{maxWord}};
    localparam logic [frameBits-1:0] minFrame = {frameLen{minWord}};
    localparam logic [frameBits-1:0] impulseFrame = frameBits'(32'h0000_00b4);

    logic                 clkResult = 1'b0;
    logic                 rst;
    logic [frameBits-1:0] sampleFrame;
    logic                 validIn;
    fxp_t                 result;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    bit checking = 1'b0;

    `include "refModel.svh"

    lookbackRecursion #(
        .numChan(numChan)
    ) uut (
        .clkResult(clkResult),
        .rst(rst),
        .sampleFrame(sampleFrame),
        .validIn(validIn),
        .result(result)
    );

    always #50 clkResult = ~clkResult;

    task automatic checkValue(string name, fxp_t got, fxp_t want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic driveFrame(logic [frameBits-1:0] frame, logic valid);
        @(posedge clkResult);
        sampleFrame <= frame;
        validIn <= valid;
    endtask

    task automatic driveRandom(int cycles, bit gapped);
        logic valid;
        for (int i = 0; i < cycles; i++) begin
            valid = gapped ? (($urandom % 3) != 0) : 1'b1;
            driveFrame(frameBits'($urandom), valid);
        end
    endtask

    // Model sees the same pre-edge inputs as the DUT registers
    always @(posedge clkResult) begin
        stepModel(rst, sampleFrame, validIn);
    end

    // Result is stable at the falling edge
    always @(negedge clkResult) begin
        if (checking) begin
            checkValue("result", result, expectedResult);
        end
    end

    always @(posedge clkResult) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles, %0d errors in %0d checks",
                timeoutCycles, errorCount, checkCount);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hb39f3f7d));
        rst = 1'b0;
        sampleFrame = '0;
        validIn = 1'b0;
        repeat (resetCycles) @(posedge clkResult);
        rst <= 1'b1;
        checking <= 1'b1;

        // Masked frames keep the output at zero
        repeat (idleCycles) driveFrame(frameBits'($urandom), 1'b0);
        @(negedge clkResult);
        checkValue("result", result, '0);

        // Impulse response
        driveFrame(impulseFrame, 1'b1);
        repeat (impulseTail) driveFrame('0, 1'b1);

        driveRandom(streamCycles, 1'b0);
        driveRandom(gapCycles, 1'b1);

        // Full scale words of both signs
        repeat (extremeCycles) driveFrame(maxFrame, 1'b1);
        repeat (extremeCycles) driveFrame(minFrame, 1'b1);
        for (int i = 0; i < extremeCycles; i++) begin
            driveFrame((i % 2 == 0) ? maxFrame : minFrame, 1'b1);
        end

        // Reset in the middle of a running stream
        driveRandom(preResetCycles, 1'b0);
        rst <= 1'b0;
        driveRandom(midResetCycles, 1'b0);
        rst <= 1'b1;
        driveRandom(postResetCycles, 1'b0);

        repeat (drainCycles) driveFrame('0, 1'b0);
        @(negedge clkResult);

        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- hw/lookbackRecursion.sv
`timescale 1ns/1ns

module lookbackRecursion
    import fxpPkg::*;
    import filterPkg::*;
#(
    // At most maxChannels, one coefTable entry per channel
    parameter int numChan = 4
) (
    input  logic                 clkResult,
    input  logic                 rst,
    input  logic [frameBits-1:0] sampleFrame,
    input  logic                 validIn,
    output fxp_t                 result
);

    fxp_t partials [numChan];

    for (genvar i = 0; i < numChan; i++) begin : chan
        recursionChannel #(
            .coef(coefTable[i])
        ) channel (
            .clkResult(clkResult),
            .rst(rst),
            .frame(sampleFrame),
            .validIn(validIn),
            .partial(partials[i])
        );
    end

    partialSum #(
        .numChan(numChan)
    ) sum (
        .clkResult(clkResult),
        .rst(rst),
        .partials(partials),
        .result(result)
    );

endmodule

//--- hw/partialSum.sv
`timescale 1ns/1ns

module partialSum
    import fxpPkg::*;
#(
    parameter int numChan = 4
) (
    input  logic clkResult,
    input  logic rst,
    input  fxp_t partials [numChan],
    output fxp_t result
);

    fxp_t total;

    // Plain wrapping adder chain
    always_comb begin
        total = '0;
        for (int i = 0; i < numChan; i++) begin
            total = total + partials[i];
        end
    end

    always_ff @(posedge clkResult) begin
        if (!rst) begin
            result <= '0;
        end else begin
            result <= total;
        end
    end

endmodule

//--- recursion/recursionChannel.sv
`timescale 1ns/1ns

module recursionChannel
    import fxpPkg::*;
    import filterPkg::*;
#(
    parameter chanCoef_t coef = '0
) (
    input  logic                 clkResult,
    input  logic                 rst,
    input  logic [frameBits-1:0] frame,
    input  logic                 validIn,
    output fxp_t                 partial
);

    cplx_t proj;
    cplx_t state;
    cplx_t held;
    cplx_t weighted;

    sampleProjector #(
        .coef(coef)
    ) projector (
        .clkResult(clkResult),
        .rst(rst),
        .frame(frame),
        .validIn(validIn),
        .proj(proj)
    );

    recursionStage #(
        .pole(coef.pole)
    ) stage (
        .clkResult(clkResult),
        .rst(rst),
        .proj(proj),
        .state(state)
    );

    // Breaks the path from the feedback loop into the weight multiplier
    always_ff @(posedge clkResult) begin
        if (!rst) begin
            held <= '0;
        end else begin
            held <= state;
        end
    end

    cplxMulReg #(
        .factor(coef.weight)
    ) weightMul (
        .clkResult(clkResult),
        .rst(rst),
        .a(held),
        .y(weighted)
    );

    // Only the real part goes on to the sum
    always_ff @(posedge clkResult) begin
        if (!rst) begin
            partial <= '0;
        end else begin
            partial <= weighted.re;
        end
    end

endmodule

//--- recursion/recursionStage.sv
`timescale 1ns/1ns

module recursionStage
    import fxpPkg::*;
#(
    parameter cplx_t pole = '0
) (
    input  logic  clkResult,
    input  logic  rst,
    input  cplx_t proj,
    output cplx_t state
);

    cplx_t fedBack;
    cplx_t nextState;

    // state[k] = proj[k] + pole * state[k-1]
    always_comb begin
        fedBack = cplxMul(pole, state);
        nextState = cplxAdd(proj, fedBack);
    end

    always_ff @(posedge clkResult) begin
        if (!rst) begin
            state <= '0;
        end else begin
            state <= nextState;
        end
    end

endmodule

//--- recursion/sampleProjector.sv
`timescale 1ns/1ns

module sampleProjector
    import fxpPkg::*;
    import filterPkg::*;
#(
    parameter chanCoef_t coef = '0
) (
    input  logic                 clkResult,
    input  logic                 rst,
    input  logic [frameBits-1:0] frame,
    input  logic                 validIn,
    output cplx_t                proj
);

    cplx_t sum;

    // Multiply-accumulate over the frame, word j at bits sampleBits*j upward
    always_comb begin
        logic signed [sampleBits-1:0] word;
        fxp_t                         wordExt;
        sum = '0;
        for (int j = 0; j < frameLen; j++) begin
            word = frame[sampleBits*j +: sampleBits];
            wordExt = fxp_t'(word);
            sum = cplxAdd(sum, cplxScale(coef.feed[j], wordExt));
        end
    end

    // Masked frames feed zero into the recursion
    always_ff @(posedge clkResult) begin
        if (!rst) begin
            proj <= '0;
        end else if (validIn) begin
            proj <= sum;
        end else begin
            proj <= '0;
        end
    end

endmodule

//--- hw/cplxMulReg.sv
`timescale 1ns/1ns

module cplxMulReg
    import fxpPkg::*;
#(
    parameter cplx_t factor = '0
) (
    input  logic  clkResult,
    input  logic  rst,
    input  cplx_t a,
    output cplx_t y
);

    cplx_t prod;

    // Multiplier sits in front of the output register
    always_comb begin
        prod = cplxMul(a, factor);
    end

    always_ff @(posedge clkResult) begin
        if (!rst) begin
            y <= '0;
        end else begin
            y <= prod;
        end
    end

endmodule

//--- common/filterPkg.sv
package filterPkg;

    import fxpPkg::*;

    localparam int sampleBits = 2;
    localparam int frameLen = 4;
    localparam int frameBits = sampleBits * frameLen;
    localparam int maxChannels = 8;

    typedef struct packed {
        cplx_t [0:frameLen-1] feed;
        cplx_t                pole;
        cplx_t                weight;
    } chanCoef_t;

    // Q8.15 values, all poles well inside the unit circle
    localparam chanCoef_t coefTable [maxChannels] = '{
        '{feed: '{mkCplx(4096, 1024), mkCplx(6144, -2048),
                  mkCplx(8192, 512), mkCplx(2048, 3072)},
          pole: mkCplx(30000, 4000), weight: mkCplx(9830, -3277)},
        '{feed: '{mkCplx(-3072, 2048), mkCplx(5120, 1536),
                  mkCplx(1024, -4096), mkCplx(7168, 256)},
          pole: mkCplx(28000, -10000), weight: mkCplx(6554, 4915)},
        '{feed: '{mkCplx(2560, -512), mkCplx(-1536, 6144),
                  mkCplx(4608, 2304), mkCplx(3584, -3584)},
          pole: mkCplx(25000, 15000), weight: mkCplx(-4915, 8192)},
        '{feed: '{mkCplx(8192, 0), mkCplx(-4096, -1024),
                  mkCplx(2048, 5120), mkCplx(-512, 1536)},
          pole: mkCplx(20000, -20000), weight: mkCplx(11469, 1638)},
        '{feed: '{mkCplx(1536, 3584), mkCplx(6656, -2560),
                  mkCplx(-2048, 1024), mkCplx(4096, 4096)},
          pole: mkCplx(15000, 24000), weight: mkCplx(3277, -6554)},
        '{feed: '{mkCplx(-5120, 768), mkCplx(3072, 3072),
                  mkCplx(7680, -1536), mkCplx(1024, 2048)},
          pole: mkCplx(31000, 2000), weight: mkCplx(2458, 819)},
        '{feed: '{mkCplx(3584, -4608), mkCplx(512, 2560),
                  mkCplx(-6144, -512), mkCplx(5632, 1024)},
          pole: mkCplx(10000, -27000), weight: mkCplx(-8192, -2458)},
        '{feed: '{mkCplx(6144, 1792), mkCplx(-2560, -3072),
                  mkCplx(3072, 4608), mkCplx(-1024, 512)},
          pole: mkCplx(27000, 12000), weight: mkCplx(5734, 7373)}
    };

endpackage

//--- common/fxpPkg.sv
package fxpPkg;

    localparam int nInt = 8;
    localparam int nFrac = 15;
    localparam int fxpWidth = nInt + nFrac + 1;

    typedef logic signed [fxpWidth-1:0] fxp_t;

    typedef struct packed {
        fxp_t re;
        fxp_t im;
    } cplx_t;

    // Wide enough for ac - bd without overflow
    localparam int prodWidth = 2 * fxpWidth + 1;
    typedef logic signed [prodWidth-1:0] prod_t;

    function automatic cplx_t mkCplx(int re, int im);
        cplx_t c;
        c.re = fxp_t'(re);
        c.im = fxp_t'(im);
        return c;
    endfunction

    function automatic cplx_t cplxAdd(cplx_t a, cplx_t b);
        cplx_t s;
        s.re = a.re + b.re;
        s.im = a.im + b.im;
        return s;
    endfunction

    // Full products, floor shift by nFrac, wrap to fxpWidth
    function automatic cplx_t cplxMul(cplx_t a, cplx_t b);
        prod_t pr;
        prod_t pi;
        cplx_t y;
        pr = prod_t'(a.re) * prod_t'(b.re) - prod_t'(a.im) * prod_t'(b.im);
        pi = prod_t'(a.re) * prod_t'(b.im) + prod_t'(a.im) * prod_t'(b.re);
        pr = pr >>> nFrac;
        pi = pi >>> nFrac;
        y.re = pr[fxpWidth-1:0];
        y.im = pi[fxpWidth-1:0];
        return y;
    endfunction

    // Integer scaling of both parts, no shift, wraps
    function automatic cplx_t cplxScale(cplx_t a, fxp_t k);
        cplx_t y;
        y.re = a.re * k;
        y.im = a.im * k;
        return y;
    endfunction

endpackage
